//--- src/branch_params.svh
`ifndef BRANCH_PARAMS_SVH
`define BRANCH_PARAMS_SVH

// width of the table index and of the global history.
// table holds 2**BHT_IDX_BITS counters.
`define BHT_IDX_BITS 4

// fall-through step to the next instruction.
`define INSTR_BYTES 4

`endif

//--- src/rv32i_types.sv
`default_nettype none

package rv32i_types;

	// pcs, instructions, operands and addresses.
	typedef logic [31:0] rv32i_word;

	// major opcodes, instr[6:0].
	typedef enum logic [6:0] {
		op_lui   = 7'b0110111,
		op_auipc = 7'b0010111,
		op_jal   = 7'b1101111,
		op_jalr  = 7'b1100111,
		op_br    = 7'b1100011, // conditional branch.
		op_load  = 7'b0000011,
		op_store = 7'b0100011,
		op_imm   = 7'b0010011,
		op_reg   = 7'b0110011,
		op_csr   = 7'b1110011
	} rv32i_opcode;

	// funct3 of op_br, instr[14:12].
	typedef enum logic [2:0] {
		beq  = 3'b000,
		bne  = 3'b001,
		blt  = 3'b100, // signed.
		bge  = 3'b101, // signed.
		bltu = 3'b110,
		bgeu = 3'b111
	} branch_funct3;

	// two-bit saturating counter, msb is the guess.
	typedef enum logic [1:0] {
		strong_nt = 2'b00,
		weak_nt   = 2'b01,
		weak_t    = 2'b10,
		strong_t  = 2'b11
	} counter_state;

endpackage

`default_nettype wire

//--- src/gshare_predictor.sv
`default_nettype none
`timescale 1ns/100ps
`include "branch_params.svh"

module gshare_predictor #(
	parameter int idx_bits = `BHT_IDX_BITS
) (
	input  logic                   clk,
	input  logic                   rst,

	// decode stage.
	input  rv32i_types::rv32i_word pc,
	input  rv32i_types::rv32i_word instr,
	output logic                   pred,
	output rv32i_types::rv32i_word pred_addr,
	output logic [idx_bits-1:0]    pred_idx,
	output logic                   is_branch,

	// training from execute.
	input  logic                   pred_update,
	input  logic                   pred_taken,
	input  logic [idx_bits-1:0]    pred_update_idx
);

	import rv32i_types::*;

	localparam int bht_entries = 2 ** idx_bits;

	counter_state        pht [bht_entries]; // pattern history table.
	logic [idx_bits-1:0] ghr;               // global history, newest in bit 0.
	logic [idx_bits-1:0] ghr_next;
	rv32i_opcode         opcode;
	rv32i_word           b_imm;
	counter_state        cur_state;

	// one saturating step toward the actual outcome.
	function automatic counter_state step_counter(
		input counter_state cur,
		input logic         taken
	);
		counter_state nxt;
		case (cur)
			strong_nt: nxt = taken ? weak_nt  : strong_nt;
			weak_nt:   nxt = taken ? weak_t   : strong_nt;
			weak_t:    nxt = taken ? strong_t : weak_nt;
			strong_t:  nxt = taken ? strong_t : weak_t;
			default:   nxt = strong_nt;
		endcase
		return nxt;
	endfunction

	assign opcode = rv32i_opcode'(instr[6:0]);

	// B-type immediate, bit 0 always zero.
	assign b_imm = {
		{20{instr[31]}},
		instr[7],
		instr[30:25],
		instr[11:8],
		1'b0
	};

	assign is_branch = (opcode == op_br);

	// gshare index.
	assign pred_idx  = pc[idx_bits+1:2] ^ ghr;
	assign cur_state = pht[pred_idx];

	// jumps and everything else fall through.
	assign pred      = is_branch & cur_state[1];
	assign pred_addr = pc + b_imm;

	assign ghr_next = (ghr << 1) | idx_bits'(pred_taken);

	always_ff @(posedge clk) begin
		if (rst) begin
			ghr <= '0;
		end else if (pred_update) begin
			ghr <= ghr_next; // shift in the resolved outcome.
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < bht_entries; i++) begin
				pht[i] <= strong_nt;
			end
		end else if (pred_update) begin
			pht[pred_update_idx] <= step_counter(pht[pred_update_idx], pred_taken);
		end
	end

endmodule

`default_nettype wire

//--- src/branch_resolver.sv
`default_nettype none
`timescale 1ns/100ps
`include "branch_params.svh"

module branch_resolver #(
	parameter int idx_bits = `BHT_IDX_BITS
) (
	input  logic                   clk,
	input  logic                   rst,

	// decode stage.
	input  logic                   id_valid,
	input  logic                   is_branch,
	input  rv32i_types::rv32i_word pc,
	input  rv32i_types::rv32i_word instr,
	input  rv32i_types::rv32i_word rs1_data,
	input  rv32i_types::rv32i_word rs2_data,
	input  logic                   pred,
	input  rv32i_types::rv32i_word pred_addr,
	input  logic [idx_bits-1:0]    pred_idx,

	// execute stage results.
	output logic                   mispredict,
	output rv32i_types::rv32i_word redirect_addr,
	output logic                   pred_update,
	output logic                   pred_taken,
	output logic [idx_bits-1:0]    pred_update_idx
);

	import rv32i_types::*;

	// ID/EX branch bundle.
	logic                ex_valid;
	rv32i_word           ex_pc;
	logic                ex_pred;
	rv32i_word           ex_pred_addr;
	logic [idx_bits-1:0] ex_idx;
	branch_funct3        ex_funct3;
	rv32i_word           ex_rs1;
	rv32i_word           ex_rs2;

	logic                taken;
	logic                capture;

	assign capture = id_valid & is_branch;

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_valid <= 1'b0;
		end else begin
			ex_valid <= capture; // drops out when nothing new arrives.
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			ex_pc        <= pc;
			ex_pred      <= pred;
			ex_pred_addr <= pred_addr;
			ex_idx       <= pred_idx;
			ex_funct3    <= branch_funct3'(instr[14:12]);
			ex_rs1       <= rs1_data;
			ex_rs2       <= rs2_data;
		end
	end

	// branch condition.
	always_comb begin
		case (ex_funct3)
			beq:     taken = (ex_rs1 == ex_rs2);
			bne:     taken = (ex_rs1 != ex_rs2);
			blt:     taken = ($signed(ex_rs1) < $signed(ex_rs2));
			bge:     taken = ($signed(ex_rs1) >= $signed(ex_rs2));
			bltu:    taken = (ex_rs1 < ex_rs2);
			bgeu:    taken = (ex_rs1 >= ex_rs2);
			default: taken = 1'b0; // reserved funct3.
		endcase
	end

	// train the predictor with every resolved branch.
	assign pred_update     = ex_valid;
	assign pred_taken      = taken;
	assign pred_update_idx = ex_idx;

	assign mispredict = ex_valid & (taken != ex_pred);

	// target when taken, else the next instruction.
	assign redirect_addr = taken ? ex_pred_addr : ex_pc + rv32i_word'(`INSTR_BYTES);

endmodule

`default_nettype wire

//--- src/branch_unit.sv
`default_nettype none
`timescale 1ns/100ps
`include "branch_params.svh"

module branch_unit (
	input  logic                   clk,
	input  logic                   rst,

	// decode stage from the core.
	input  logic                   id_valid,
	input  rv32i_types::rv32i_word pc,
	input  rv32i_types::rv32i_word instr,
	input  rv32i_types::rv32i_word rs1_data,
	input  rv32i_types::rv32i_word rs2_data,

	// prediction, same cycle.
	output logic                   pred,
	output rv32i_types::rv32i_word pred_addr,

	// resolution, one cycle later.
	output logic                   mispredict,
	output rv32i_types::rv32i_word redirect_addr
);

	logic                     is_branch;
	logic [`BHT_IDX_BITS-1:0] pred_idx;
	logic                     pred_update;
	logic                     pred_taken;
	logic [`BHT_IDX_BITS-1:0] pred_update_idx;

	gshare_predictor #(
		.idx_bits (`BHT_IDX_BITS)
	) i_gshare_predictor (
		.clk             (clk),
		.rst             (rst),
		.pc              (pc),
		.instr           (instr),
		.pred            (pred),
		.pred_addr       (pred_addr),
		.pred_idx        (pred_idx),
		.is_branch       (is_branch),
		.pred_update     (pred_update),
		.pred_taken      (pred_taken),
		.pred_update_idx (pred_update_idx)
	);

	branch_resolver #(
		.idx_bits (`BHT_IDX_BITS)
	) i_branch_resolver (
		.clk             (clk),
		.rst             (rst),
		.id_valid        (id_valid),
		.is_branch       (is_branch),
		.pc              (pc),
		.instr           (instr),
		.rs1_data        (rs1_data),
		.rs2_data        (rs2_data),
		.pred            (pred),
		.pred_addr       (pred_addr),
		.pred_idx        (pred_idx),
		.mispredict      (mispredict),
		.redirect_addr   (redirect_addr),
		.pred_update     (pred_update),
		.pred_taken      (pred_taken),
		.pred_update_idx (pred_update_idx)
	);

endmodule

`default_nettype wire

//--- tests/tb_clock_gen.sv
`default_nettype none
`timescale 1ns/100ps

module tb_clock_gen #(
	parameter int half_period = 20, // 40 ns clock.
	parameter int rst_cycles  = 3
) (
	input  logic rst_req,
	output logic clk,
	output logic rst
);

	int rst_count = rst_cycles;

	initial begin
		clk = 1'b0;
		forever #(half_period) clk = ~clk;
	end

	// rst_req restarts the reset sequence.
	always @(posedge clk) begin
		if (rst_req)
			rst_count <= rst_cycles;
		else if (rst_count > 0)
			rst_count <= rst_count - 1;
	end

	assign rst = (rst_count != 0);

endmodule

`default_nettype wire

//--- tests/branch_unit_properties.sv
`default_nettype none
`timescale 1ns/100ps

module branch_unit_properties (
	input logic                   clk,
	input logic                   rst,
	input logic                   id_valid,
	input rv32i_types::rv32i_word instr,
	input logic                   pred,
	input logic                   mispredict
);

	import rv32i_types::*;

	int unsigned reset_fails = 0;
	int unsigned idle_fails  = 0;
	int unsigned pred_fails  = 0;
	int unsigned fail_count;
	logic        is_br_op;
	logic        valid_branch;

	assign is_br_op     = (rv32i_opcode'(instr[6:0]) == op_br);
	assign valid_branch = id_valid & is_br_op;
	assign fail_count   = reset_fails + idle_fails + pred_fails;

	// nothing resolves right after reset.
	mispredict_after_reset: assert property (@(posedge clk) rst |=> !mispredict)
		else begin
			reset_fails++;
			$error("mispredict raised in the cycle after reset");
		end

	mispredict_needs_branch: assert property (
		@(posedge clk) disable iff (rst) !valid_branch |=> !mispredict)
		else begin
			idle_fails++;
			$error("mispredict raised without a valid branch in the previous cycle");
		end

	// jumps and other opcodes never predict taken.
	pred_only_on_branch: assert property (@(posedge clk) disable iff (rst) !is_br_op |-> !pred)
		else begin
			pred_fails++;
			$error("pred high for an opcode other than a conditional branch");
		end

endmodule

bind branch_unit branch_unit_properties i_branch_unit_properties (
	.clk        (clk),
	.rst        (rst),
	.id_valid   (id_valid),
	.instr      (instr),
	.pred       (pred),
	.mispredict (mispredict)
);

`default_nettype wire

//--- tests/tb_branch_unit.sv
`default_nettype none
`timescale 1ns/100ps
`include "branch_params.svh"

module tb_branch_unit;

	import rv32i_types::*;

	localparam int        idx_w      = `BHT_IDX_BITS;
	localparam rv32i_word loop_pc    = 32'h0000_0240;
	localparam rv32i_word loop_offs  = 32'hffff_ffe0; // back 32 bytes.
	localparam rv32i_word addi_instr = {12'd5, 5'd1, 3'b000, 5'd3, op_imm};
	localparam rv32i_word jal_instr  = {20'h00100, 5'd1, op_jal};

	logic      clk;
	logic      rst;
	logic      rst_req;
	logic      id_valid;
	rv32i_word pc;
	rv32i_word instr;
	rv32i_word rs1_data;
	rv32i_word rs2_data;
	logic      pred;
	rv32i_word pred_addr;
	logic      mispredict;
	rv32i_word redirect_addr;

	// reference gshare state.
	counter_state     pht_m [2 ** idx_w];
	logic [idx_w-1:0] ghr_m;

	// branch that resolves in the next cycle.
	logic             pend_valid;
	logic             pend_pred;
	logic             pend_taken;
	logic [idx_w-1:0] pend_idx;
	rv32i_word        pend_pc;
	rv32i_word        pend_target;

	int checks;
	int errors;
	int timeouts;

	tb_clock_gen #(.half_period(20), .rst_cycles(3)) i_tb_clock_gen (
		.rst_req (rst_req),
		.clk     (clk),
		.rst     (rst)
	);

	branch_unit i_branch_unit (
		.clk           (clk),
		.rst           (rst),
		.id_valid      (id_valid),
		.pc            (pc),
		.instr         (instr),
		.rs1_data      (rs1_data),
		.rs2_data      (rs2_data),
		.pred          (pred),
		.pred_addr     (pred_addr),
		.mispredict    (mispredict),
		.redirect_addr (redirect_addr)
	);

	function automatic rv32i_word encode_branch(input branch_funct3 f3, input rv32i_word offs);
		return {offs[12], offs[10:5], 5'd2, 5'd1, f3, offs[4:1], offs[11], op_br};
	endfunction

	function automatic logic cond_taken(input branch_funct3 f3, input rv32i_word a,
			input rv32i_word b);
		rv32i_word sa;
		rv32i_word sb;
		sa = a ^ 32'h8000_0000; // biased, so signed order becomes unsigned order.
		sb = b ^ 32'h8000_0000;
		case (f3)
			beq:     return a == b;
			bne:     return a != b;
			blt:     return sa < sb;
			bge:     return !(sa < sb);
			bltu:    return a < b;
			bgeu:    return !(a < b);
			default: return 1'b0;
		endcase
	endfunction

	function automatic counter_state train(input counter_state cur, input logic taken);
		if (taken && cur != strong_t)
			return counter_state'(cur + 2'd1);
		if (!taken && cur != strong_nt)
			return counter_state'(cur - 2'd1);
		return cur;
	endfunction

	function automatic logic model_predicts(input rv32i_word addr);
		return pht_m[addr[idx_w+1:2] ^ ghr_m][1];
	endfunction

	// pc near base that maps to target under the model history.
	function automatic rv32i_word aim_pc(input rv32i_word base,
			input logic [idx_w-1:0] target);
		return {base[31:idx_w+2], target ^ ghr_m, base[1:0]};
	endfunction

	function automatic void reset_model();
		foreach (pht_m[i])
			pht_m[i] = strong_nt;
		ghr_m = '0;
		pend_valid = 1'b0;
	endfunction

	task automatic compare_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch %s: got %h, expected %h at time %0t", name, got, exp, $time);
		end
	endtask

	task automatic compare_word(input string name, input rv32i_word got, input rv32i_word exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch %s: got %h, expected %h at time %0t", name, got, exp, $time);
		end
	endtask

	task automatic wait_reset_release(input int max_cycles);
		int n;
		n = 0;
		@(negedge clk);
		while (rst && n < max_cycles) begin
			@(negedge clk);
			n++;
		end
		if (rst) begin
			timeouts++;
			$display("timeout: reset still asserted after %0d cycles", max_cycles);
		end
	endtask

	// one decode cycle, checked against the model at the falling edge.
	task automatic step(input logic valid, input rv32i_word pc_v, input rv32i_word instr_v,
			input rv32i_word a, input rv32i_word b, input rv32i_word offs);
		logic             br;
		logic             exp_pred;
		logic [idx_w-1:0] idx;
		rv32i_word        fall;
		@(posedge clk);
		id_valid <= valid;
		pc       <= pc_v;
		instr    <= instr_v;
		rs1_data <= a;
		rs2_data <= b;
		@(negedge clk);
		br       = (instr_v[6:0] == op_br);
		idx      = pc_v[idx_w+1:2] ^ ghr_m;
		exp_pred = br & pht_m[idx][1];
		compare_bit("pred", pred, exp_pred);
		if (br)
			compare_word("pred_addr", pred_addr, pc_v + offs);
		compare_bit("mispredict", mispredict, pend_valid & (pend_taken != pend_pred));
		if (pend_valid) begin
			fall = pend_pc + `INSTR_BYTES;
			compare_word("redirect_addr", redirect_addr, pend_taken ? pend_target : fall);
			pht_m[pend_idx] = train(pht_m[pend_idx], pend_taken); // trained at this edge.
			ghr_m = {ghr_m[idx_w-2:0], pend_taken};
		end
		pend_valid  = valid & br;
		pend_pred   = exp_pred;
		pend_idx    = idx;
		pend_taken  = cond_taken(branch_funct3'(instr_v[14:12]), a, b);
		pend_pc     = pc_v;
		pend_target = pc_v + offs;
	endtask

	task automatic issue_branch(input rv32i_word pc_v, input branch_funct3 f3,
			input rv32i_word offs, input rv32i_word a, input rv32i_word b);
		step(1'b1, pc_v, encode_branch(f3, offs), a, b, offs);
	endtask

	task automatic idle();
		step(1'b0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0);
	endtask

	task automatic test_reset_predictions();
		rv32i_word x;
		x = $urandom;
		issue_branch(32'h0000_1000, bne, 32'h0000_0008, x, x);
		issue_branch(32'h0000_1004, bne, 32'hffff_fff0, x, x);
		issue_branch(32'h0000_2008, bne, 32'h0000_0ffe, x, x);
		issue_branch(32'h0000_300c, bne, 32'hffff_f000, x, x);
		idle();
	endtask

	task automatic test_non_branch();
		rv32i_word x;
		x = $urandom;
		// two taken outcomes leave counter 5 at weak_t.
		issue_branch(aim_pc(32'h0000_0400, idx_w'(5)), beq, 32'h0000_0010, x, x);
		idle();
		issue_branch(aim_pc(32'h0000_0400, idx_w'(5)), beq, 32'h0000_0010, x, x);
		idle();
		step(1'b1, 32'h0000_0404, addi_instr, x, x, 32'h0);
		step(1'b1, 32'h0000_0408, jal_instr, x, x, 32'h0);
		// lands on counter 5 only if the history was left alone.
		issue_branch(aim_pc(32'h0000_040c, idx_w'(5)), bne, 32'h0000_0020, x, x);
		idle();
	endtask

	task automatic test_conditions();
		branch_funct3 conds [6];
		rv32i_word    a;
		rv32i_word    b;
		rv32i_word    pc_r;
		rv32i_word    offs_r;
		conds = '{beq, bne, blt, bge, bltu, bgeu};
		for (int c = 0; c < 6; c++) begin
			for (int k = 0; k < 3; k++) begin
				a      = $urandom;
				b      = (k == 0) ? $urandom : (k == 1) ? a : a ^ 32'h8000_0000;
				pc_r   = $urandom & 32'hffff_fffc;
				offs_r = $urandom & 32'h0000_1ffe;
				if (offs_r[12])
					offs_r = offs_r | 32'hffff_e000; // sign extend.
				issue_branch(pc_r, conds[c], offs_r, a, b);
			end
		end
		idle();
	endtask

	task automatic test_loop_training();
		rv32i_word x;
		int        tries;
		tries = 0;
		while (!model_predicts(loop_pc) && tries < 16) begin
			x = $urandom;
			issue_branch(loop_pc, beq, loop_offs, x, x);
			idle();
			tries++;
		end
		if (!model_predicts(loop_pc)) begin
			errors++;
			$display("loop branch still predicted not-taken after %0d iterations", tries);
		end
		x = $urandom;
		issue_branch(loop_pc, beq, loop_offs, x, x);
		compare_bit("pred", pred, 1'b1);
		idle();
		issue_branch(loop_pc, beq, loop_offs, x, x + 1); // loop exit.
		idle();
		compare_bit("mispredict", mispredict, 1'b1);
		compare_word("redirect_addr", redirect_addr, loop_pc + `INSTR_BYTES);
	endtask

	task automatic test_back_to_back();
		rv32i_word x;
		x = $urandom;
		// counter 9 down to strong_nt, then one step up to weak_nt.
		for (int i = 0; i < 3; i++) begin
			issue_branch(aim_pc(loop_pc, idx_w'(9)), bne, loop_offs, x, x);
			idle();
		end
		issue_branch(aim_pc(loop_pc, idx_w'(9)), beq, loop_offs, x, x);
		idle();
		// second one still sees weak_nt and the old history.
		issue_branch(aim_pc(loop_pc, idx_w'(9)), beq, loop_offs, x, x);
		issue_branch(aim_pc(loop_pc + 32'h40, idx_w'(9)), bne, 32'h0000_0100, x, x + 1);
		issue_branch(loop_pc, beq, loop_offs, x, x);
		idle();
	endtask

	task automatic test_mid_run_reset();
		rv32i_word x;
		x = $urandom;
		for (int i = 0; i < 3; i++) begin // counter 0 up to strong_t.
			issue_branch(aim_pc(loop_pc, '0), beq, loop_offs, x, x);
			idle();
		end
		@(posedge clk);
		rst_req  <= 1'b1;
		id_valid <= 1'b0;
		@(posedge clk);
		rst_req <= 1'b0;
		wait_reset_release(10);
		reset_model();
		x = $urandom;
		issue_branch(loop_pc, beq, loop_offs, x, x);
		compare_bit("pred", pred, 1'b0);
		idle();
	endtask

	initial begin
		void'($urandom(32'h6f3f));
		checks   = 0;
		errors   = 0;
		timeouts = 0;
		rst_req  <= 1'b0;
		id_valid <= 1'b0;
		pc       <= '0;
		instr    <= '0;
		rs1_data <= '0;
		rs2_data <= '0;
		reset_model();
		wait_reset_release(10);
		test_reset_predictions();
		test_non_branch();
		test_conditions();
		test_loop_training();
		test_back_to_back();
		test_mid_run_reset();
		$display("checks %0d, mismatches %0d, timeouts %0d, assertion failures %0d",
			checks, errors, timeouts, i_branch_unit.i_branch_unit_properties.fail_count);
		if (errors == 0 && timeouts == 0 &&
				i_branch_unit.i_branch_unit_properties.fail_count == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
+incdir+src
src/rv32i_types.sv
src/gshare_predictor.sv
src/branch_resolver.sv
src/branch_unit.sv
tests/tb_clock_gen.sv
tests/branch_unit_properties.sv
tests/tb_branch_unit.sv

//--- Makefile
# Verilator build and run for the branch unit testbench.

VERILATOR  ?= verilator
TOP        ?= tb_branch_unit
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
TIMESCALE  ?= 1ns/100ps
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
RUN_ARGS   ?= +verilator+error+limit+100

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard src/*.sv src/*.svh tests/*.sv)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@./$(SIM) $(RUN_ARGS) > $(LOG) 2>&1; \
	cat $(LOG); \
	if grep -q "TEST FAILED" $(LOG); then exit 1; fi; \
	if ! grep -q "TEST OK" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --timescale $(TIMESCALE) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
